// ==== common/rv_isa_pkg.sv ====
package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;

  // alu funct3, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [2:0] F3_LB   = 3'b000;
  localparam logic [2:0] F3_LH   = 3'b001;
  localparam logic [2:0] F3_LW   = 3'b010;
  localparam logic [2:0] F3_LBU  = 3'b100;
  localparam logic [2:0] F3_LHU  = 3'b101;
  localparam logic [2:0] F3_SB   = 3'b000;
  localparam logic [2:0] F3_SH   = 3'b001;
  localparam logic [2:0] F3_SW   = 3'b010;
  localparam logic [2:0] F3_JALR = 3'b000;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm_11_0;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_11_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_4_0;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm_31_12;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } u;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } inst_t;

endpackage

// ==== common/decode_ctrl_pkg.sv ====
package decode_ctrl_pkg;

  localparam int OP_COUNT = 28;

  // alu ops, register and immediate forms share a bit
  localparam int OP_ADD  = 0;
  localparam int OP_SUB  = 1;
  localparam int OP_SLL  = 2;
  localparam int OP_SLT  = 3;
  localparam int OP_SLTU = 4;
  localparam int OP_XOR  = 5;
  localparam int OP_SRL  = 6;
  localparam int OP_SRA  = 7;
  localparam int OP_OR   = 8;
  localparam int OP_AND  = 9;

  localparam int OP_LUI   = 10;
  localparam int OP_AUIPC = 11;

  localparam int OP_LB  = 12;
  localparam int OP_LH  = 13;
  localparam int OP_LW  = 14;
  localparam int OP_LBU = 15;
  localparam int OP_LHU = 16;

  localparam int OP_SB = 17;
  localparam int OP_SH = 18;
  localparam int OP_SW = 19;

  localparam int OP_JAL  = 20;
  localparam int OP_JALR = 21;

  localparam int OP_BEQ  = 22;
  localparam int OP_BNE  = 23;
  localparam int OP_BLT  = 24;
  localparam int OP_BGE  = 25;
  localparam int OP_BLTU = 26;
  localparam int OP_BGEU = 27;

  localparam int IMM_SEL_W = 3;

  localparam logic [IMM_SEL_W-1:0] IMM_NONE  = 3'd0;
  localparam logic [IMM_SEL_W-1:0] IMM_I     = 3'd1;
  localparam logic [IMM_SEL_W-1:0] IMM_SHAMT = 3'd2; // slli, srli, srai
  localparam logic [IMM_SEL_W-1:0] IMM_S     = 3'd3;
  localparam logic [IMM_SEL_W-1:0] IMM_B     = 3'd4;
  localparam logic [IMM_SEL_W-1:0] IMM_U     = 3'd5;
  localparam logic [IMM_SEL_W-1:0] IMM_J     = 3'd6;

endpackage

// ==== decode/op_decoder.sv ====
module op_decoder (
  input  rv_isa_pkg::inst_t                      inst_if,
  output logic [decode_ctrl_pkg::OP_COUNT-1:0]  op_pre,
  output logic [decode_ctrl_pkg::IMM_SEL_W-1:0] imm_sel,
  output logic                                  imm_en_pre,
  output logic                                  ren1_pre,
  output logic                                  ren2_pre
);
  import rv_isa_pkg::*;
  import decode_ctrl_pkg::*;

  logic [OP_COUNT-1:0]  op_hit;
  logic [IMM_SEL_W-1:0] fmt_sel;
  logic                 rs1_used;
  logic                 rs2_used;
  logic                 f7_base;
  logic                 f7_alt;
  logic                 legal;

  assign f7_base = (inst_if.r.funct7 == F7_BASE);
  assign f7_alt  = (inst_if.r.funct7 == F7_ALT);

  always_comb
  begin
    op_hit   = '0;
    fmt_sel  = IMM_NONE;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    case (inst_if.r.opcode)
      OPC_LUI:
      begin
        op_hit[OP_LUI] = 1'b1;
        fmt_sel        = IMM_U;
      end
      OPC_AUIPC:
      begin
        op_hit[OP_AUIPC] = 1'b1;
        fmt_sel          = IMM_U;
      end
      OPC_JAL:
      begin
        op_hit[OP_JAL] = 1'b1;
        fmt_sel        = IMM_J;
      end
      OPC_JALR:
      begin
        op_hit[OP_JALR] = (inst_if.r.funct3 == F3_JALR);
        fmt_sel         = IMM_I;
        rs1_used        = 1'b1;
      end
      OPC_BRANCH:
      begin
        fmt_sel  = IMM_B;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        case (inst_if.r.funct3)
          F3_BEQ:  op_hit[OP_BEQ]  = 1'b1;
          F3_BNE:  op_hit[OP_BNE]  = 1'b1;
          F3_BLT:  op_hit[OP_BLT]  = 1'b1;
          F3_BGE:  op_hit[OP_BGE]  = 1'b1;
          F3_BLTU: op_hit[OP_BLTU] = 1'b1;
          F3_BGEU: op_hit[OP_BGEU] = 1'b1;
          default: ; // 010, 011 unused
        endcase
      end
      OPC_LOAD:
      begin
        fmt_sel  = IMM_I;
        rs1_used = 1'b1;
        case (inst_if.r.funct3)
          F3_LB:   op_hit[OP_LB]  = 1'b1;
          F3_LH:   op_hit[OP_LH]  = 1'b1;
          F3_LW:   op_hit[OP_LW]  = 1'b1;
          F3_LBU:  op_hit[OP_LBU] = 1'b1;
          F3_LHU:  op_hit[OP_LHU] = 1'b1;
          default: ;
        endcase
      end
      OPC_STORE:
      begin
        fmt_sel  = IMM_S;
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        case (inst_if.r.funct3)
          F3_SB:   op_hit[OP_SB] = 1'b1;
          F3_SH:   op_hit[OP_SH] = 1'b1;
          F3_SW:   op_hit[OP_SW] = 1'b1;
          default: ;
        endcase
      end
      OPC_OP_IMM:
      begin
        fmt_sel  = IMM_I;
        rs1_used = 1'b1;
        case (inst_if.r.funct3)
          F3_ADD_SUB: op_hit[OP_ADD]  = 1'b1; // no subi
          F3_SLT:     op_hit[OP_SLT]  = 1'b1;
          F3_SLTU:    op_hit[OP_SLTU] = 1'b1;
          F3_XOR:     op_hit[OP_XOR]  = 1'b1;
          F3_OR:      op_hit[OP_OR]   = 1'b1;
          F3_AND:     op_hit[OP_AND]  = 1'b1;
          F3_SLL:
          begin
            fmt_sel        = IMM_SHAMT;
            op_hit[OP_SLL] = f7_base;
          end
          F3_SRL_SRA:
          begin
            fmt_sel        = IMM_SHAMT;
            op_hit[OP_SRL] = f7_base;
            op_hit[OP_SRA] = f7_alt;
          end
          default: ;
        endcase
      end
      OPC_OP:
      begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        case (inst_if.r.funct3)
          F3_ADD_SUB:
          begin
            op_hit[OP_ADD] = f7_base;
            op_hit[OP_SUB] = f7_alt;
          end
          F3_SRL_SRA:
          begin
            op_hit[OP_SRL] = f7_base;
            op_hit[OP_SRA] = f7_alt;
          end
          F3_SLL:  op_hit[OP_SLL]  = f7_base;
          F3_SLT:  op_hit[OP_SLT]  = f7_base;
          F3_SLTU: op_hit[OP_SLTU] = f7_base;
          F3_XOR:  op_hit[OP_XOR]  = f7_base;
          F3_OR:   op_hit[OP_OR]   = f7_base;
          F3_AND:  op_hit[OP_AND]  = f7_base;
          default: ;
        endcase
      end
      default: ; // system, csr, fence and the rest
    endcase
  end

  // unmatched words carry no immediate and read nothing
  assign legal      = |op_hit;
  assign op_pre     = op_hit;
  assign imm_sel    = legal ? fmt_sel : IMM_NONE;
  assign imm_en_pre = legal && (fmt_sel != IMM_NONE);
  assign ren1_pre   = legal & rs1_used;
  assign ren2_pre   = legal & rs2_used;

endmodule

// ==== decode/imm_generator.sv ====
module imm_generator (
  input  rv_isa_pkg::inst_t                      inst_if,
  input  logic [decode_ctrl_pkg::IMM_SEL_W-1:0] imm_sel,
  output logic [rv_isa_pkg::XLEN-1:0]           imm_pre
);
  import decode_ctrl_pkg::*;

  // bits land at their architectural positions, no sign extension
  always_comb
  begin
    imm_pre = '0;
    case (imm_sel)
      IMM_I:
        imm_pre[11:0] = inst_if.i.imm_11_0;
      IMM_SHAMT:
        imm_pre[4:0] = inst_if.i.imm_11_0[4:0]; // shamt only
      IMM_S:
        imm_pre[11:0] = {inst_if.s.imm_11_5, inst_if.s.imm_4_0};
      IMM_B:
        imm_pre[12:1] = {inst_if.b.imm_12,
                         inst_if.b.imm_11,
                         inst_if.b.imm_10_5,
                         inst_if.b.imm_4_1};
      IMM_U:
        imm_pre[31:12] = inst_if.u.imm_31_12;
      IMM_J:
        imm_pre[20:1] = {inst_if.j.imm_20,
                         inst_if.j.imm_19_12,
                         inst_if.j.imm_11,
                         inst_if.j.imm_10_1};
      default: ; // IMM_NONE
    endcase
  end

endmodule

// ==== decode/id_ex_register.sv ====
module id_ex_register (
  input  logic                                  clk,
  input  logic                                  rst_b,
  input  logic                                  hold_ctl,
  input  logic                                  clear_ctl,
  input  logic [rv_isa_pkg::XLEN-1:0]           pc_if,
  input  logic [rv_isa_pkg::XLEN-1:0]           inst_if,
  input  logic [decode_ctrl_pkg::OP_COUNT-1:0]  op_pre,
  input  logic [rv_isa_pkg::XLEN-1:0]           imm_pre,
  input  logic                                  imm_en_pre,
  input  logic                                  ren1_pre,
  input  logic                                  ren2_pre,
  output logic [rv_isa_pkg::XLEN-1:0]           pc_dec,
  output logic [rv_isa_pkg::XLEN-1:0]           inst_dec,
  output logic [decode_ctrl_pkg::OP_COUNT-1:0]  op_dec,
  output logic [rv_isa_pkg::XLEN-1:0]           imm_dec,
  output logic                                  imm_en_dec,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]     rs1_dec,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]     rs2_dec,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]     rd_dec,
  output logic                                  ren1_dec,
  output logic                                  ren2_dec,
  output logic                                  illegal_inst_dec
);

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
    begin
      pc_dec     <= '0;
      inst_dec   <= '0;
      op_dec     <= '0;
      imm_dec    <= '0;
      imm_en_dec <= 1'b0;
      rs1_dec    <= '0;
      rs2_dec    <= '0;
      rd_dec     <= '0;
      ren1_dec   <= 1'b0;
      ren2_dec   <= 1'b0;
    end
    else if (hold_ctl)
    begin
      // stall, hold wins over clear
    end
    else if (clear_ctl)
    begin
      pc_dec     <= '0; // bubble
      inst_dec   <= '0;
      op_dec     <= '0;
      imm_dec    <= '0;
      imm_en_dec <= 1'b0;
      rs1_dec    <= '0;
      rs2_dec    <= '0;
      rd_dec     <= '0;
      ren1_dec   <= 1'b0;
      ren2_dec   <= 1'b0;
    end
    else
    begin
      pc_dec     <= pc_if;
      inst_dec   <= inst_if;
      op_dec     <= op_pre;
      imm_dec    <= imm_pre;
      imm_en_dec <= imm_en_pre;
      rs1_dec    <= inst_if[19:15];
      rs2_dec    <= inst_if[24:20];
      rd_dec     <= inst_if[11:7];
      ren1_dec   <= ren1_pre;
      ren2_dec   <= ren2_pre;
    end
  end

  // a bubble is all zero so it never flags
  assign illegal_inst_dec = ~|op_dec & |inst_dec;

endmodule

// ==== decode/decode_stage.sv ====
module decode_stage (
  input  logic                                  clk,
  input  logic                                  rst_b,
  input  logic [rv_isa_pkg::XLEN-1:0]           pc_if,
  input  logic [rv_isa_pkg::XLEN-1:0]           inst_if,
  input  logic                                  hold_ctl,
  input  logic                                  clear_ctl,
  output logic [rv_isa_pkg::XLEN-1:0]           pc_dec,
  output logic [rv_isa_pkg::XLEN-1:0]           inst_dec,
  output logic [decode_ctrl_pkg::OP_COUNT-1:0]  op_dec,
  output logic [rv_isa_pkg::XLEN-1:0]           imm_dec,
  output logic                                  imm_en_dec,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]     rs1_dec,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]     rs2_dec,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0]     rd_dec,
  output logic                                  ren1_dec,
  output logic                                  ren2_dec,
  output logic                                  illegal_inst_dec
);
  import rv_isa_pkg::*;
  import decode_ctrl_pkg::*;

  logic [OP_COUNT-1:0]  op_pre;
  logic [IMM_SEL_W-1:0] imm_sel;
  logic [XLEN-1:0]      imm_pre;
  logic                 imm_en_pre;
  logic                 ren1_pre;
  logic                 ren2_pre;

  op_decoder op_decoder_i (
    .inst_if    (inst_if),
    .op_pre     (op_pre),
    .imm_sel    (imm_sel),
    .imm_en_pre (imm_en_pre),
    .ren1_pre   (ren1_pre),
    .ren2_pre   (ren2_pre)
  );

  imm_generator imm_generator_i (
    .inst_if (inst_if),
    .imm_sel (imm_sel),
    .imm_pre (imm_pre)
  );

  id_ex_register id_ex_register_i (
    .clk              (clk),
    .rst_b            (rst_b),
    .hold_ctl         (hold_ctl),
    .clear_ctl        (clear_ctl),
    .pc_if            (pc_if),
    .inst_if          (inst_if),
    .op_pre           (op_pre),
    .imm_pre          (imm_pre),
    .imm_en_pre       (imm_en_pre),
    .ren1_pre         (ren1_pre),
    .ren2_pre         (ren2_pre),
    .pc_dec           (pc_dec),
    .inst_dec         (inst_dec),
    .op_dec           (op_dec),
    .imm_dec          (imm_dec),
    .imm_en_dec       (imm_en_dec),
    .rs1_dec          (rs1_dec),
    .rs2_dec          (rs2_dec),
    .rd_dec           (rd_dec),
    .ren1_dec         (ren1_dec),
    .ren2_dec         (ren2_dec),
    .illegal_inst_dec (illegal_inst_dec)
  );

endmodule

// ==== tb/decode_stage_properties.sv ====
module decode_stage_properties (
  input logic                                 clk,
  input logic                                 rst_b,
  input logic                                 hold_ctl,
  input logic [rv_isa_pkg::XLEN-1:0]          pc_dec,
  input logic [rv_isa_pkg::XLEN-1:0]          inst_dec,
  input logic [decode_ctrl_pkg::OP_COUNT-1:0] op_dec,
  input logic [rv_isa_pkg::XLEN-1:0]          imm_dec,
  input logic                                 imm_en_dec,
  input logic [rv_isa_pkg::REG_ADDR_W-1:0]    rs1_dec,
  input logic [rv_isa_pkg::REG_ADDR_W-1:0]    rs2_dec,
  input logic [rv_isa_pkg::REG_ADDR_W-1:0]    rd_dec,
  input logic                                 ren1_dec,
  input logic                                 ren2_dec,
  input logic                                 illegal_inst_dec
);
  timeunit 1ns;
  timeprecision 1ps;

  hold_keeps_outputs: assert property (@(posedge clk) disable iff (!rst_b)
    hold_ctl |=> $stable({pc_dec, inst_dec, op_dec, imm_dec, imm_en_dec, rs1_dec,
                          rs2_dec, rd_dec, ren1_dec, ren2_dec, illegal_inst_dec}))
    else $error("stage outputs changed while hold_ctl was high");

  op_at_most_one: assert property (@(posedge clk) disable iff (!rst_b) $onehot0(op_dec))
    else $error("op_dec has more than one bit set");

  // an unmatched word carries no op, no immediate and no reads
  illegal_has_no_op: assert property (@(posedge clk) disable iff (!rst_b)
    illegal_inst_dec |-> (op_dec == '0 && imm_dec == '0 && !imm_en_dec &&
                          !ren1_dec && !ren2_dec))
    else $error("illegal_inst_dec is high with decode outputs set");

endmodule

// ==== tb/decode_stage_tb.sv ====
module decode_stage_tb;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;
  import decode_ctrl_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int NUM_WORDS    = 600;
  localparam int RESET_CYCLES = 5;
  localparam int TABLE_SIZE   = 40;

  // funct3 per op position, lowest entry first
  localparam logic [29:0] ALU_F3    = {3'd7, 3'd6, 3'd5, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0, 3'd0};
  localparam logic [14:0] LOAD_F3   = {3'd5, 3'd4, 3'd2, 3'd1, 3'd0};
  localparam logic [17:0] BRANCH_F3 = {3'd7, 3'd6, 3'd5, 3'd4, 3'd1, 3'd0};

  logic                  clk;
  logic                  rst_b;
  logic [XLEN-1:0]       pc_if;
  logic [XLEN-1:0]       inst_if;
  logic                  hold_ctl;
  logic                  clear_ctl;
  logic [XLEN-1:0]       pc_dec;
  logic [XLEN-1:0]       inst_dec;
  logic [OP_COUNT-1:0]   op_dec;
  logic [XLEN-1:0]       imm_dec;
  logic                  imm_en_dec;
  logic [REG_ADDR_W-1:0] rs1_dec;
  logic [REG_ADDR_W-1:0] rs2_dec;
  logic [REG_ADDR_W-1:0] rd_dec;
  logic                  ren1_dec;
  logic                  ren2_dec;
  logic                  illegal_inst_dec;

  // decode table: match fields, op position, format letter
  int          n_ent;
  logic [6:0]  t_opc [TABLE_SIZE];
  logic        t_f3_chk [TABLE_SIZE];
  logic [2:0]  t_f3 [TABLE_SIZE];
  logic        t_f7_chk [TABLE_SIZE];
  logic [6:0]  t_f7 [TABLE_SIZE];
  int          t_op [TABLE_SIZE];
  logic [7:0]  t_fmt [TABLE_SIZE];

  // one-entry model of the id/ex register
  logic [31:0] m_pc;
  logic [31:0] m_inst;
  logic [27:0] m_op;
  logic [31:0] m_imm;
  logic        m_imm_en;
  logic        m_ren1;
  logic        m_ren2;
  string       cur_test;
  int          errors;
  int unsigned seed_val;

  decode_stage dut_i (
    .clk              (clk),
    .rst_b            (rst_b),
    .pc_if            (pc_if),
    .inst_if          (inst_if),
    .hold_ctl         (hold_ctl),
    .clear_ctl        (clear_ctl),
    .pc_dec           (pc_dec),
    .inst_dec         (inst_dec),
    .op_dec           (op_dec),
    .imm_dec          (imm_dec),
    .imm_en_dec       (imm_en_dec),
    .rs1_dec          (rs1_dec),
    .rs2_dec          (rs2_dec),
    .rd_dec           (rd_dec),
    .ren1_dec         (ren1_dec),
    .ren2_dec         (ren2_dec),
    .illegal_inst_dec (illegal_inst_dec)
  );

  bind id_ex_register decode_stage_properties properties_i (.*);

  task automatic add_entry(input logic [6:0] opc, input logic f3_chk, input logic [2:0] f3,
                           input logic f7_chk, input logic [6:0] f7, input int op,
                           input logic [7:0] fmt);
    t_opc[n_ent]    = opc;
    t_f3_chk[n_ent] = f3_chk;
    t_f3[n_ent]     = f3;
    t_f7_chk[n_ent] = f7_chk;
    t_f7[n_ent]     = f7;
    t_op[n_ent]     = op;
    t_fmt[n_ent]    = fmt;
    n_ent++;
  endtask

  task automatic build_table();
    logic [6:0] f7;
    logic       shift;
    n_ent = 0;
    for (int op = OP_ADD; op <= OP_AND; op++)
    begin
      f7    = (op == OP_SUB || op == OP_SRA) ? 7'h20 : 7'h00;
      shift = (op == OP_SLL || op == OP_SRL || op == OP_SRA);
      add_entry(7'h33, 1'b1, ALU_F3[op*3 +: 3], 1'b1, f7, op, "R");
      if (op != OP_SUB) // no immediate sub
        add_entry(7'h13, 1'b1, ALU_F3[op*3 +: 3], shift, f7, op, shift ? "H" : "I");
    end
    add_entry(7'h37, 1'b0, 3'd0, 1'b0, 7'h00, OP_LUI, "U");
    add_entry(7'h17, 1'b0, 3'd0, 1'b0, 7'h00, OP_AUIPC, "U");
    for (int k = 0; k < 5; k++)
      add_entry(7'h03, 1'b1, LOAD_F3[k*3 +: 3], 1'b0, 7'h00, OP_LB + k, "I");
    for (int k = 0; k < 3; k++)
      add_entry(7'h23, 1'b1, k[2:0], 1'b0, 7'h00, OP_SB + k, "S");
    add_entry(7'h6f, 1'b0, 3'd0, 1'b0, 7'h00, OP_JAL, "J");
    add_entry(7'h67, 1'b1, 3'd0, 1'b0, 7'h00, OP_JALR, "I");
    for (int k = 0; k < 6; k++)
      add_entry(7'h63, 1'b1, BRANCH_F3[k*3 +: 3], 1'b0, 7'h00, OP_BEQ + k, "B");
  endtask

  function automatic int find_entry(input logic [31:0] w);
    for (int k = 0; k < n_ent; k++)
      if (w[6:0] == t_opc[k] && (!t_f3_chk[k] || w[14:12] == t_f3[k]) &&
          (!t_f7_chk[k] || w[31:25] == t_f7[k]))
        return k;
    return -1;
  endfunction

  function automatic logic [31:0] expected_imm(input logic [31:0] w, input logic [7:0] fmt);
    case (fmt)
      "I": return {20'b0, w[31:20]};
      "H": return {27'b0, w[24:20]};
      "S": return {20'b0, w[31:25], w[11:7]};
      "B": return {19'b0, w[31], w[7], w[30:25], w[11:8], 1'b0};
      "U": return {w[31:12], 12'b0};
      "J": return {11'b0, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default: return 32'b0; // register form
    endcase
  endfunction

  function automatic logic [31:0] random_word();
    int          idx;
    int unsigned pick;
    logic [31:0] w;
    pick = $urandom % 8;
    w    = $urandom;
    if (pick < 4)
    begin
      idx     = $urandom % n_ent;
      w[6:0]  = t_opc[idx];
      if (t_f3_chk[idx])
        w[14:12] = t_f3[idx];
      if (t_f7_chk[idx])
        w[31:25] = t_f7[idx];
    end
    else if (pick == 4)
      w[6:0] = 7'h73; // system and csr space
    else if (pick == 5)
      w[6:0] = 7'h0f; // fence
    else if (pick == 6)
      w = 32'b0;
    return w;
  endfunction

  task automatic clear_model();
    m_pc     = '0;
    m_inst   = '0;
    m_op     = '0;
    m_imm    = '0;
    m_imm_en = 1'b0;
    m_ren1   = 1'b0;
    m_ren2   = 1'b0;
  endtask

  // called at the edge, before new inputs are driven
  task automatic capture_model();
    int         idx;
    logic [7:0] fmt;
    if (hold_ctl)
      cur_test = "hold";
    else if (clear_ctl)
    begin
      cur_test = "clear";
      clear_model();
    end
    else
    begin
      idx    = find_entry(inst_if);
      m_pc   = pc_if;
      m_inst = inst_if;
      if (idx >= 0)
      begin
        fmt      = t_fmt[idx];
        cur_test = "legal_decode";
        m_op     = 28'b1 << t_op[idx];
        m_imm    = expected_imm(inst_if, fmt);
        m_imm_en = (fmt != "R");
        m_ren1   = (fmt != "U") && (fmt != "J");
        m_ren2   = (fmt == "R") || (fmt == "S") || (fmt == "B");
      end
      else
      begin
        cur_test = "illegal_word";
        m_op     = '0;
        m_imm    = '0;
        m_imm_en = 1'b0;
        m_ren1   = 1'b0;
        m_ren2   = 1'b0;
      end
    end
  endtask

  task automatic check_field(input string test_name, input string field,
                             input logic [31:0] exp_val, input logic [31:0] act_val);
    if (exp_val !== act_val)
    begin
      errors++;
      $display("Fail %s %s: expected %h, actual %h", test_name, field, exp_val, act_val);
    end
  endtask

  task automatic check_outputs();
    logic exp_illegal;
    exp_illegal = (m_op == '0) && (m_inst != '0);
    check_field(cur_test, "pc_dec", m_pc, pc_dec);
    check_field(cur_test, "inst_dec", m_inst, inst_dec);
    check_field(cur_test, "op_dec", {4'b0, m_op}, {4'b0, op_dec});
    check_field(cur_test, "imm_dec", m_imm, imm_dec);
    check_field(cur_test, "imm_en_dec", {31'b0, m_imm_en}, {31'b0, imm_en_dec});
    check_field(cur_test, "rs1_dec", {27'b0, m_inst[19:15]}, {27'b0, rs1_dec});
    check_field(cur_test, "rs2_dec", {27'b0, m_inst[24:20]}, {27'b0, rs2_dec});
    check_field(cur_test, "rd_dec", {27'b0, m_inst[11:7]}, {27'b0, rd_dec});
    check_field(cur_test, "ren1_dec", {31'b0, m_ren1}, {31'b0, ren1_dec});
    check_field(cur_test, "ren2_dec", {31'b0, m_ren2}, {31'b0, ren2_dec});
    check_field(cur_test, "illegal_inst_dec", {31'b0, exp_illegal}, {31'b0, illegal_inst_dec});
  endtask

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #((NUM_WORDS + 20) * CLK_PERIOD);
    $display("watchdog expired before the test sequence completed");
    $display("TEST FAILED");
    $finish;
  end

  initial
  begin
    seed_val  = $urandom(25);
    errors    = 0;
    rst_b     = 1'b0;
    pc_if     = '0;
    inst_if   = '0;
    hold_ctl  = 1'b0;
    clear_ctl = 1'b0;
    build_table();
    clear_model();
    cur_test = "reset";
    repeat (RESET_CYCLES) @(negedge clk);
    check_outputs();
    @(posedge clk);
    rst_b <= 1'b1;
    for (int i = 0; i < NUM_WORDS; i++)
    begin
      @(posedge clk);
      capture_model();
      pc_if     <= $urandom & 32'hffff_fffc;
      inst_if   <= random_word();
      hold_ctl  <= ($urandom % 10) == 0;
      clear_ctl <= ($urandom % 10) == 0;
      @(negedge clk);
      check_outputs();
    end
    $display("decode stage run done, %0d errors", errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== src.f ====
common/rv_isa_pkg.sv
common/decode_ctrl_pkg.sv
decode/op_decoder.sv
decode/imm_generator.sv
decode/id_ex_register.sv
decode/decode_stage.sv
tb/decode_stage_properties.sv
tb/decode_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module decode_stage_tb -f src.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/Vdecode_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi

echo "simulation passed"
exit 0
